// File: sys_pkg.sv
package sys_pkg;

	// Register bus field widths
	typedef logic [3:0]  spam_did_t;
	typedef logic [7:0]  spam_addr_t;
	typedef logic [31:0] spam_data_t;

	typedef logic [7:0]  led_t;

	// One-cycle request from the bus master
	typedef struct packed {
		logic       valid;
		logic       r_nw;  // High for a read
		spam_did_t  did;
		spam_addr_t addr;
		spam_data_t data;
	} spam_req_t;

	// Device response, OR-combined across devices
	typedef struct packed {
		logic       busy_b;  // Data valid this cycle
		spam_data_t data;
	} spam_rsp_t;

	// Observed memory request stream
	typedef struct packed {
		logic valid;
		logic is_read;
	} mem_req_t;

	localparam spam_did_t SPAM_DID_STATUS = 4'd0;
	localparam spam_did_t SPAM_DID_TIMER  = 4'd1;

	localparam spam_addr_t STATUS_ADDR_STATUS   = 8'd0;
	localparam spam_addr_t STATUS_ADDR_LED_MASK = 8'd1;
	localparam spam_addr_t STATUS_ADDR_CLEAR    = 8'd2;

	localparam spam_addr_t TIMER_ADDR_COUNT = 8'd0;

	localparam spam_data_t UNMAPPED_DATA  = 32'hDEAD_BEEF;
	localparam led_t       LED_MASK_RESET = 8'hFF;

	// Defaults for the top level parameters
	localparam int unsigned DEF_RST_STRETCH    = 16;
	localparam int unsigned DEF_FLASH_CYCLES   = 5000000;  // About 100 ms of LED flash
	localparam int unsigned DEF_HEARTBEAT_BITS = 27;

endpackage

// File: reset_sequencer.sv
module reset_sequencer #(
	parameter int unsigned RST_STRETCH = 16
) (
	input  logic cclk,
	input  logic cclk_rst_cause_b,
	input  logic corerst_btn,
	output logic core_rst_b
);

	logic [2:0]             btn_sync;
	logic                   seq_rst_b;
	logic [RST_STRETCH-1:0] rel_seq;

	// Button is asynchronous to cclk
	always_ff @(posedge cclk) begin
		btn_sync <= {btn_sync[1:0], corerst_btn};
	end

	assign seq_rst_b = cclk_rst_cause_b & ~btn_sync[2];  // Either cause holds reset

	// Assert at once, release after RST_STRETCH clean edges
	always_ff @(posedge cclk or negedge seq_rst_b) begin
		if (!seq_rst_b) begin
			rel_seq <= '0;
		end else begin
			rel_seq <= {rel_seq[RST_STRETCH-2:0], 1'b1};
		end
	end

	assign core_rst_b = rel_seq[RST_STRETCH-1];

endmodule

// File: activity_monitor.sv
module activity_monitor import sys_pkg::*; #(
	parameter int unsigned FLASH_CYCLES = DEF_FLASH_CYCLES
) (
	input  logic     cclk,
	input  logic     core_rst_b,
	input  mem_req_t mem_req,
	input  logic     clear_triggered,
	output logic     flashing,
	output logic     triggered
);

	localparam int unsigned CNT_W = $clog2(FLASH_CYCLES + 1);

	logic [CNT_W-1:0] recent;
	logic             rd_seen;

	assign rd_seen = mem_req.valid & mem_req.is_read;

	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			recent    <= '0;
			triggered <= 1'b0;
		end else begin
			if (rd_seen) begin
				recent    <= CNT_W'(1);  // Restart the flash
				triggered <= 1'b1;       // A read wins over a clear
			end else begin
				if (recent == CNT_W'(FLASH_CYCLES)) begin
					recent <= '0;
				end else if (recent != '0) begin
					recent <= recent + 1'b1;
				end
				if (clear_triggered) begin
					triggered <= 1'b0;
				end
			end
		end
	end

	assign flashing = (recent != '0);

endmodule

// File: status_regs.sv
module status_regs import sys_pkg::*; #(
	parameter int unsigned HEARTBEAT_BITS = DEF_HEARTBEAT_BITS
) (
	input  logic      cclk,
	input  logic      core_rst_b,
	input  spam_req_t req,
	input  logic      flashing,
	input  logic      triggered,
	output spam_rsp_t rsp,
	output logic      clear_triggered,
	output led_t      leds
);

	logic [HEARTBEAT_BITS-1:0] heartbeat;
	led_t                      led_mask;
	led_t                      led_raw;
	logic                      wr;
	logic                      rd;
	spam_data_t                rd_data;

	assign wr = req.valid & ~req.r_nw;
	assign rd = req.valid & req.r_nw;

	// Free-running, top bit blinks an LED
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			heartbeat <= '0;
		end else begin
			heartbeat <= heartbeat + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			led_mask        <= LED_MASK_RESET;
			clear_triggered <= 1'b0;
		end else begin
			if (wr && req.addr == STATUS_ADDR_LED_MASK) begin
				led_mask <= req.data[7:0];
			end
			clear_triggered <= wr && (req.addr == STATUS_ADDR_CLEAR);  // Data ignored
		end
	end

	always_comb begin
		case (req.addr)
			STATUS_ADDR_STATUS:   rd_data = {30'd0, flashing, triggered};
			STATUS_ADDR_LED_MASK: rd_data = {24'd0, led_mask};
			default:              rd_data = '0;
		endcase
	end

	// Zero data when idle keeps the OR bus clean
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			rsp <= '0;
		end else begin
			rsp.busy_b <= rd;
			rsp.data   <= rd ? rd_data : '0;
		end
	end

	assign led_raw = {4'd0, core_rst_b, triggered, flashing, heartbeat[HEARTBEAT_BITS-1]};
	assign leds    = led_raw & led_mask;

endmodule

// File: spam_timer.sv
module spam_timer import sys_pkg::*; (
	input  logic      cclk,
	input  logic      core_rst_b,
	input  spam_req_t req,
	output spam_rsp_t rsp
);

	spam_data_t count;
	spam_data_t count_nxt;
	logic       ld;
	logic       rd;

	assign ld = req.valid & ~req.r_nw & (req.addr == TIMER_ADDR_COUNT);
	assign rd = req.valid & req.r_nw;

	always_comb begin
		if (ld) begin
			count_nxt = req.data;  // Load replaces this cycle's increment
		end else begin
			count_nxt = count + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			count <= '0;
		end else begin
			count <= count_nxt;
		end
	end

	// Read returns the value taken at the sampling edge
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			rsp <= '0;
		end else begin
			rsp.busy_b <= rd;
			if (rd && req.addr == TIMER_ADDR_COUNT) begin
				rsp.data <= count_nxt;
			end else begin
				rsp.data <= '0;  // Other addresses and idle
			end
		end
	end

endmodule

// File: spam_fabric.sv
module spam_fabric import sys_pkg::*; (
	input  logic      cclk,
	input  logic      core_rst_b,
	input  spam_req_t spam_req,
	output spam_req_t status_req,
	output spam_req_t timer_req,
	input  spam_rsp_t status_rsp,
	input  spam_rsp_t timer_rsp,
	output spam_rsp_t spam_rsp
);

	logic      hit_status;
	logic      hit_timer;
	logic      unmapped_rd;
	spam_rsp_t unmapped_rsp;

	// Single id decode for all devices
	assign hit_status = (spam_req.did == SPAM_DID_STATUS);
	assign hit_timer  = (spam_req.did == SPAM_DID_TIMER);

	always_comb begin
		status_req       = spam_req;
		status_req.valid = spam_req.valid & hit_status;
	end

	always_comb begin
		timer_req       = spam_req;
		timer_req.valid = spam_req.valid & hit_timer;
	end

	assign unmapped_rd = spam_req.valid & spam_req.r_nw & ~hit_status & ~hit_timer;

	// Answer reads nobody owns so the master never waits forever
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			unmapped_rsp <= '0;
		end else begin
			unmapped_rsp.busy_b <= unmapped_rd;
			unmapped_rsp.data   <= unmapped_rd ? UNMAPPED_DATA : '0;
		end
	end

	// Idle devices drive zeros, so a plain OR merges them
	assign spam_rsp = status_rsp | timer_rsp | unmapped_rsp;

endmodule

// File: soc_sys.sv
module soc_sys import sys_pkg::*; #(
	parameter int unsigned RST_STRETCH    = DEF_RST_STRETCH,
	parameter int unsigned FLASH_CYCLES   = DEF_FLASH_CYCLES,
	parameter int unsigned HEARTBEAT_BITS = DEF_HEARTBEAT_BITS
) (
	input  logic      cclk,
	input  logic      cclk_rst_cause_b,
	input  logic      corerst_btn,
	input  spam_req_t spam_req,
	input  mem_req_t  mem_req,
	output spam_rsp_t spam_rsp,
	output led_t      leds,
	output logic      core_rst_b
);

	spam_req_t status_req;
	spam_req_t timer_req;
	spam_rsp_t status_rsp;
	spam_rsp_t timer_rsp;
	logic      clear_triggered;
	logic      flashing;
	logic      triggered;

	reset_sequencer #(
		.RST_STRETCH (RST_STRETCH)
	) reset_sequencer_i (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn      (corerst_btn),
		.core_rst_b       (core_rst_b)
	);

	spam_fabric spam_fabric_i (
		.cclk       (cclk),
		.core_rst_b (core_rst_b),
		.spam_req   (spam_req),
		.status_req (status_req),
		.timer_req  (timer_req),
		.status_rsp (status_rsp),
		.timer_rsp  (timer_rsp),
		.spam_rsp   (spam_rsp)
	);

	status_regs #(
		.HEARTBEAT_BITS (HEARTBEAT_BITS)
	) status_regs_i (
		.cclk            (cclk),
		.core_rst_b      (core_rst_b),
		.req             (status_req),
		.flashing        (flashing),
		.triggered       (triggered),
		.rsp             (status_rsp),
		.clear_triggered (clear_triggered),
		.leds            (leds)
	);

	activity_monitor #(
		.FLASH_CYCLES (FLASH_CYCLES)
	) activity_monitor_i (
		.cclk            (cclk),
		.core_rst_b      (core_rst_b),
		.mem_req         (mem_req),
		.clear_triggered (clear_triggered),
		.flashing        (flashing),
		.triggered       (triggered)
	);

	spam_timer spam_timer_i (
		.cclk       (cclk),
		.core_rst_b (core_rst_b),
		.req        (timer_req),
		.rsp        (timer_rsp)
	);

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
	parameter real         PERIOD     = 4.0,
	parameter int unsigned RST_CYCLES = 3
) (
	output logic cclk,
	output logic cclk_rst_cause_b
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		cclk = 1'b0;
		forever #(PERIOD / 2.0) cclk = ~cclk;
	end

	// Power-on reset cause, released on a falling edge
	initial begin
		cclk_rst_cause_b = 1'b0;
		repeat (RST_CYCLES) @(posedge cclk);
		@(negedge cclk);
		cclk_rst_cause_b = 1'b1;
	end

endmodule

// File: tb_soc_sys.sv
module tb_soc_sys import sys_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned RST_STRETCH    = 16;
	localparam int unsigned FLASH_CYCLES   = 20;
	localparam int unsigned HEARTBEAT_BITS = 4;
	localparam int unsigned BTN_SYNC       = 3;  // Button synchronizer depth
	localparam int unsigned BTN_HOLD       = 5;
	// Per-test cycle budgets plus margin
	localparam int unsigned WATCHDOG_CYCLES = 100 + 150 + 300 + 300 + 400 + 250 + 500;

	logic      cclk;
	logic      cclk_rst_cause_b;
	logic      corerst_btn;
	spam_req_t spam_req;
	mem_req_t  mem_req;
	spam_rsp_t spam_rsp;
	led_t      leds;
	logic      core_rst_b;

	spam_data_t cyc = '0;  // Edge counter
	spam_rsp_t  exp_rsp;
	spam_rsp_t  exp_bus;
	led_t       exp_leds;
	led_t       m_mask;
	int         m_flash_left;
	logic       m_trig;
	logic       m_clr;
	spam_data_t m_ticks;
	spam_data_t tm_base;
	spam_data_t tm_base_cyc;  // Edge of the last timer load

	logic checks_on = 1'b0;
	int   errors = 0;
	int   test_start_errors = 0;
	int   test_idx = 0;
	int   pass_cnt = 0;
	int   fail_cnt = 0;
	int   seed = 6;

	tb_clock_gen #(
		.PERIOD     (4.0),
		.RST_CYCLES (3)
	) clock_gen_i (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b)
	);

	soc_sys #(
		.RST_STRETCH    (RST_STRETCH),
		.FLASH_CYCLES   (FLASH_CYCLES),
		.HEARTBEAT_BITS (HEARTBEAT_BITS)
	) dut_i (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn      (corerst_btn),
		.spam_req         (spam_req),
		.mem_req          (mem_req),
		.spam_rsp         (spam_rsp),
		.leds             (leds),
		.core_rst_b       (core_rst_b)
	);

	// Response expected one cycle after a read
	function automatic spam_rsp_t expected_read(input spam_req_t r);
		spam_rsp_t e;
		e = '0;
		if (r.valid && r.r_nw) begin
			e.busy_b = 1'b1;
			if (r.did == SPAM_DID_STATUS) begin
				if (r.addr == STATUS_ADDR_STATUS) begin
					e.data = {30'd0, (m_flash_left != 0), m_trig};
				end else if (r.addr == STATUS_ADDR_LED_MASK) begin
					e.data = {24'd0, m_mask};
				end
			end else if (r.did == SPAM_DID_TIMER) begin
				if (r.addr == TIMER_ADDR_COUNT) begin
					e.data = tm_base + (cyc - tm_base_cyc);
				end
			end else begin
				e.data = UNMAPPED_DATA;
			end
		end
		return e;
	endfunction

	always @(posedge cclk) begin
		cyc <= cyc + 1'b1;
		if (core_rst_b !== 1'b1) begin
			exp_rsp      <= '0;
			m_mask       <= LED_MASK_RESET;
			m_flash_left <= 0;
			m_trig       <= 1'b0;
			m_clr        <= 1'b0;
			m_ticks      <= '0;
			tm_base      <= '0;
			tm_base_cyc  <= cyc;  // Timer counts up from zero after reset
		end else begin
			m_ticks <= m_ticks + 1'b1;
			exp_rsp <= expected_read(spam_req);
			m_clr   <= spam_req.valid && !spam_req.r_nw && spam_req.did == SPAM_DID_STATUS
				&& spam_req.addr == STATUS_ADDR_CLEAR;
			if (spam_req.valid && !spam_req.r_nw && spam_req.did == SPAM_DID_STATUS
					&& spam_req.addr == STATUS_ADDR_LED_MASK) begin
				m_mask <= spam_req.data[7:0];
			end
			if (spam_req.valid && !spam_req.r_nw && spam_req.did == SPAM_DID_TIMER
					&& spam_req.addr == TIMER_ADDR_COUNT) begin
				tm_base     <= spam_req.data;
				tm_base_cyc <= cyc;
			end
			if (mem_req.valid && mem_req.is_read) begin
				m_flash_left <= FLASH_CYCLES;
				m_trig       <= 1'b1;
			end else begin
				if (m_flash_left != 0) begin
					m_flash_left <= m_flash_left - 1;
				end
				if (m_clr) begin
					m_trig <= 1'b0;
				end
			end
		end
	end

	assign exp_bus  = (core_rst_b === 1'b1) ? exp_rsp : '0;
	assign exp_leds = (core_rst_b === 1'b1) ? ({4'd0, 1'b1, m_trig, (m_flash_left != 0),
		m_ticks[HEARTBEAT_BITS-1]} & m_mask) : '0;

	rsp_check: assert property (@(posedge cclk) !checks_on || spam_rsp == exp_bus)
		else begin
			$display("Mismatch spam_rsp: got %h expected %h", $sampled(spam_rsp), $sampled(exp_bus));
			errors++;
		end

	leds_check: assert property (@(posedge cclk) !checks_on || leds == exp_leds)
		else begin
			$display("Mismatch leds: got %h expected %h", $sampled(leds), $sampled(exp_leds));
			errors++;
		end

	rst_quiet_check: assert property (@(posedge cclk) !checks_on || core_rst_b || !spam_rsp.busy_b)
		else begin
			$display("Bus answered a request while the core was held in reset");
			errors++;
		end

	task automatic send(input logic r_nw, input spam_did_t did, input spam_addr_t addr,
			input spam_data_t data);
		@(negedge cclk);
		spam_req = '{valid: 1'b1, r_nw: r_nw, did: did, addr: addr, data: data};
	endtask

	task automatic release_bus();
		@(negedge cclk);
		spam_req = '0;
	endtask

	task automatic bus_write(input spam_did_t did, input spam_addr_t addr, input spam_data_t data);
		send(1'b0, did, addr, data);
		release_bus();
	endtask

	task automatic bus_read(input spam_did_t did, input spam_addr_t addr);
		send(1'b1, did, addr, '0);
		release_bus();
	endtask

	task automatic pulse_mem(input logic is_read);
		@(negedge cclk);
		mem_req = '{valid: 1'b1, is_read: is_read};
		@(negedge cclk);
		mem_req = '0;
	endtask

	// Counts edges from now until the core reset drops
	task automatic wait_assert(input int expected);
		int n;
		n = 0;
		while (core_rst_b === 1'b1 && n < 32) begin
			@(negedge cclk);
			n++;
		end
		assert (n == expected) else begin
			$display("Mismatch core_rst_b assert delay: got %0h expected %0h", n, expected);
			errors++;
		end
	endtask

	task automatic wait_release(input int expected, input string cause);
		int n;
		n = 0;
		while (core_rst_b !== 1'b1 && n < 64) begin
			@(negedge cclk);
			n++;
		end
		assert (core_rst_b === 1'b1) else begin
			$display("core_rst_b stayed low for 64 cycles after the %s cleared", cause);
			errors++;
		end
		assert (n == expected) else begin
			$display("Mismatch core_rst_b release delay: got %0h expected %0h", n, expected);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int n;
		repeat (2) @(negedge cclk);  // Let the last responses be checked
		n = errors - test_start_errors;
		test_idx++;
		if (n == 0) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
		$display("Test %0d %s: %s, %0d errors", test_idx, name, (n == 0) ? "passed" : "failed", n);
		test_start_errors = errors;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge cclk);
		$display("Watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int i;
		int n;
		corerst_btn = 1'b0;
		spam_req    = '0;
		mem_req     = '0;
		@(negedge cclk);
		checks_on = 1'b1;

		@(posedge cclk_rst_cause_b);
		wait_release(RST_STRETCH, "reset cause");
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK);
		end_test("power-on reset");

		bus_write(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK, $random(seed));
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK);
		corerst_btn = 1'b1;
		wait_assert(BTN_SYNC);
		// Requests while the core is held in reset must be ignored
		spam_req = '{valid: 1'b1, r_nw: 1'b0, did: SPAM_DID_STATUS,
			addr: STATUS_ADDR_LED_MASK, data: '0};
		repeat (BTN_HOLD - BTN_SYNC - 1) send(1'b1, 4'h7, 8'h00, '0);
		release_bus();
		corerst_btn = 1'b0;
		wait_release(BTN_SYNC + RST_STRETCH, "reset button");
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK);
		end_test("reset button");

		for (i = 0; i < 5; i++) begin
			n = 1 + {$random(seed)} % 12;
			bus_write(SPAM_DID_TIMER, TIMER_ADDR_COUNT, $random(seed));
			repeat (n - 1) @(negedge cclk);
			bus_read(SPAM_DID_TIMER, TIMER_ADDR_COUNT);
		end
		repeat (4) send(1'b1, SPAM_DID_TIMER, TIMER_ADDR_COUNT, '0);
		send(1'b1, SPAM_DID_TIMER, 8'h05, '0);  // Unused timer address
		send(1'b1, SPAM_DID_STATUS, STATUS_ADDR_STATUS, '0);
		send(1'b1, SPAM_DID_TIMER, TIMER_ADDR_COUNT, '0);
		release_bus();
		end_test("timer load and read");

		pulse_mem(1'b1);
		repeat (FLASH_CYCLES + 4) send(1'b1, SPAM_DID_STATUS, STATUS_ADDR_STATUS, '0);
		release_bus();
		pulse_mem(1'b0);
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_STATUS);
		bus_write(SPAM_DID_STATUS, STATUS_ADDR_CLEAR, $random(seed));
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_STATUS);
		send(1'b0, SPAM_DID_STATUS, STATUS_ADDR_CLEAR, '0);
		@(negedge cclk);
		spam_req = '0;
		mem_req  = '{valid: 1'b1, is_read: 1'b1};  // Read meets the clear pulse
		@(negedge cclk);
		mem_req = '0;
		bus_read(SPAM_DID_STATUS, STATUS_ADDR_STATUS);
		bus_read(SPAM_DID_STATUS, 8'h7C);
		end_test("activity indicator");

		for (i = 0; i < 6; i++) begin
			bus_write(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK, $random(seed));
			if (i % 2 == 0) begin
				pulse_mem(1'b1);
			end
			repeat (12) @(negedge cclk);
		end
		bus_write(SPAM_DID_STATUS, STATUS_ADDR_LED_MASK, LED_MASK_RESET);
		repeat (17) @(negedge cclk);  // Two heartbeat toggles
		end_test("led mask");

		for (i = 2; i < 16; i++) begin
			bus_read(spam_did_t'(i), spam_addr_t'($random(seed)));
			bus_write(spam_did_t'(i), spam_addr_t'($random(seed)), $random(seed));
		end
		send(1'b1, 4'hF, 8'h00, '0);
		send(1'b1, SPAM_DID_TIMER, TIMER_ADDR_COUNT, '0);
		send(1'b1, 4'h9, 8'h03, '0);
		release_bus();
		end_test("unmapped device");

		$display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
		if (fail_cnt == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
sys_pkg.sv
reset_sequencer.sv
activity_monitor.sv
status_regs.sv
spam_timer.sv
spam_fabric.sv
soc_sys.sv
tb_clock_gen.sv
tb_soc_sys.sv

// File: Bender.yml
package:
  name: soc_sys

sources:
  - sys_pkg.sv
  - reset_sequencer.sv
  - activity_monitor.sv
  - status_regs.sv
  - spam_timer.sv
  - spam_fabric.sv
  - soc_sys.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_soc_sys.sv
